/* Makefile */
# Verilator build and run of the read-only crossbar testbench

VERILATOR ?= verilator
TOP       ?= tb_xbar_rd
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* sim.f */
+incdir+.
xbar_pkg.sv
xbar_rd_if.sv
xbar_addr_decode.sv
xbar_rd_demux.sv
xbar_decerr_slv.sv
xbar_rd_mux.sv
xbar_rd_top.sv
tb_xbar_rd.sv

/* tb_xbar_model.svh */
/*
  Reference model for the crossbar testbench, included in the testbench top.
  Random source, target prediction, expected response queues and compare tasks.
*/
`ifndef TB_XBAR_MODEL_SVH
`define TB_XBAR_MODEL_SVH

// Xorshift state, fixed seed
logic [31:0] rng_state = 32'h53e9;

// Expected responses per slave port and tracked ID, in issue order
data_t   exp_data_q [NUM_SLV_PORTS][TRACK_NUM][$];
slv_id_t exp_id_q   [NUM_SLV_PORTS][TRACK_NUM][$];
resp_t   exp_resp_q [NUM_SLV_PORTS][TRACK_NUM][$];

function automatic logic [31:0] rand_next();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// Highest-indexed hit first, then default, then decode error
function automatic port_sel_t predict_target(addr_t addr, logic den, port_sel_t dport);
  for (int r = NUM_RULES - 1; r >= 0; r--) begin
    if ((addr >= RULE_START[r]) && (addr < RULE_END[r])) begin
      return RULE_PORT[r];
    end
  end
  if (den) begin
    return dport;
  end
  return port_sel_t'(NUM_MST_PORTS);
endfunction

task automatic push_expected(int unsigned port, slv_id_t id, data_t data, resp_t resp);
  exp_data_q[port][id[ID_USED-1:0]].push_back(data);
  exp_id_q[port][id[ID_USED-1:0]].push_back(id);
  exp_resp_q[port][id[ID_USED-1:0]].push_back(resp);
endtask

task automatic stop_run(string why);
  $display("%s", why);
  $display("TESTS FAILED");
  $fatal(1);
endtask

// Master-side request, source field over the original ID
task automatic compare_req(int unsigned port, mst_id_u got_id, mst_id_u exp_id,
                           addr_t got_addr, addr_t exp_addr);
  if (got_id.f.src !== exp_id.f.src) begin
    stop_run($sformatf("FAILED t=%0t m_ar_id_o[%0d].src got %h expected %h",
                       $time, port, got_id.f.src, exp_id.f.src));
  end else if (got_id.f.id !== exp_id.f.id) begin
    stop_run($sformatf("FAILED t=%0t m_ar_id_o[%0d].id got %h expected %h",
                       $time, port, got_id.f.id, exp_id.f.id));
  end else if (got_addr !== exp_addr) begin
    stop_run($sformatf("FAILED t=%0t m_ar_addr_o[%0d] got %h expected %h",
                       $time, port, got_addr, exp_addr));
  end
endtask

// Slave-side response
task automatic compare_rsp(int unsigned port, data_t got_data, data_t exp_data,
                           slv_id_t got_id, slv_id_t exp_id,
                           resp_t got_resp, resp_t exp_resp);
  if (got_id !== exp_id) begin
    stop_run($sformatf("FAILED t=%0t s_r_id_o[%0d] got %h expected %h",
                       $time, port, got_id, exp_id));
  end else if (got_resp !== exp_resp) begin
    stop_run($sformatf("FAILED t=%0t s_r_resp_o[%0d] got %h expected %h",
                       $time, port, got_resp, exp_resp));
  end else if (got_data !== exp_data) begin
    stop_run($sformatf("FAILED t=%0t s_r_data_o[%0d] got %h expected %h",
                       $time, port, got_data, exp_data));
  end
endtask

`endif

/* tb_xbar_rd.sv */
/*
  Testbench for the read-only crossbar. Random reads from both slave ports,
  random-latency targets on the master ports, responses checked by the model.
*/
`default_nettype none

module tb_xbar_rd import xbar_pkg::*; ();

  localparam int unsigned NUM_READS     = 300;
  localparam int unsigned ISSUE_TIMEOUT = 40000;
  localparam int unsigned DRAIN_TIMEOUT = 2000;

  logic clk_i;
  logic rst_n_i;

  // Slave side
  logic      [NUM_SLV_PORTS-1:0] s_ar_valid   = '0;
  addr_t     [NUM_SLV_PORTS-1:0] s_ar_addr    = '0;
  slv_id_t   [NUM_SLV_PORTS-1:0] s_ar_id      = '0;
  logic      [NUM_SLV_PORTS-1:0] s_r_ready    = '0;
  logic      [NUM_SLV_PORTS-1:0] default_en   = '0;
  port_sel_t [NUM_SLV_PORTS-1:0] default_port = '0;
  logic      [NUM_SLV_PORTS-1:0] s_ar_ready;
  logic      [NUM_SLV_PORTS-1:0] s_r_valid;
  data_t     [NUM_SLV_PORTS-1:0] s_r_data;
  slv_id_t   [NUM_SLV_PORTS-1:0] s_r_id;
  resp_t     [NUM_SLV_PORTS-1:0] s_r_resp;

  // Master side
  logic  [NUM_MST_PORTS-1:0]               m_ar_valid;
  addr_t [NUM_MST_PORTS-1:0]               m_ar_addr;
  logic  [NUM_MST_PORTS-1:0][MST_ID_W-1:0] m_ar_id;
  logic  [NUM_MST_PORTS-1:0]               m_r_ready;
  logic  [NUM_MST_PORTS-1:0]               m_ar_ready = '0;
  logic  [NUM_MST_PORTS-1:0]               m_r_valid  = '0;
  data_t [NUM_MST_PORTS-1:0]               m_r_data   = '0;
  logic  [NUM_MST_PORTS-1:0][MST_ID_W-1:0] m_r_id     = '0;
  resp_t [NUM_MST_PORTS-1:0]               m_r_resp   = '0;

  // Initiator state
  int unsigned issued   [NUM_SLV_PORTS];
  int unsigned gap      [NUM_SLV_PORTS];
  port_sel_t   pend_tgt [NUM_SLV_PORTS];

  // Target FIFOs of accepted reads
  addr_t               tgt_addr_q [NUM_MST_PORTS][$];
  logic [MST_ID_W-1:0] tgt_id_q   [NUM_MST_PORTS][$];
  int unsigned         tgt_dly    [NUM_MST_PORTS];

  `include "tb_xbar_model.svh"

  xbar_rd_top dut0 (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .s_ar_valid_i   (s_ar_valid),
    .s_ar_addr_i    (s_ar_addr),
    .s_ar_id_i      (s_ar_id),
    .s_r_ready_i    (s_r_ready),
    .default_en_i   (default_en),
    .default_port_i (default_port),
    .s_ar_ready_o   (s_ar_ready),
    .s_r_valid_o    (s_r_valid),
    .s_r_data_o     (s_r_data),
    .s_r_id_o       (s_r_id),
    .s_r_resp_o     (s_r_resp),
    .m_ar_valid_o   (m_ar_valid),
    .m_ar_addr_o    (m_ar_addr),
    .m_ar_id_o      (m_ar_id),
    .m_r_ready_o    (m_r_ready),
    .m_ar_ready_i   (m_ar_ready),
    .m_r_valid_i    (m_r_valid),
    .m_r_data_i     (m_r_data),
    .m_r_id_i       (m_r_id),
    .m_r_resp_i     (m_r_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  // Mapped ranges, the overlay window and the hole above 0x3000_0000
  function automatic addr_t random_addr();
    logic [31:0] r;
    logic [31:0] k;
    r = rand_next();
    k = rand_next() % 5;
    case (k)
      0, 1, 2: return {k[3:0], r[27:0]};
      3:       return {8'h08, r[23:0]};
      default: return 32'h3000_0000 + (r % 32'hd000_0000);
    endcase
  endfunction

  function automatic logic all_issued();
    for (int i = 0; i < NUM_SLV_PORTS; i++) begin
      if (issued[i] < NUM_READS) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic logic all_drained();
    for (int i = 0; i < NUM_SLV_PORTS; i++) begin
      for (int t = 0; t < TRACK_NUM; t++) begin
        if (exp_data_q[i][t].size() != 0) begin
          return 1'b0;
        end
      end
    end
    for (int j = 0; j < NUM_MST_PORTS; j++) begin
      if (tgt_addr_q[j].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Each slave transfer must show up at the predicted master port, same edge
  task automatic check_requests();
    logic [NUM_MST_PORTS-1:0] claimed;
    port_sel_t                t;
    mst_id_u                  got_id;
    mst_id_u                  exp_id;
    claimed = '0;
    for (int i = 0; i < NUM_SLV_PORTS; i++) begin
      if (s_ar_valid[i] && s_ar_ready[i]) begin
        t = pend_tgt[i];
        if (t == port_sel_t'(NUM_MST_PORTS)) begin
          push_expected(i, s_ar_id[i], DECERR_DATA, RESP_DECERR);
        end else if (!(m_ar_valid[t] && m_ar_ready[t])) begin
          stop_run($sformatf("slave port %0d read was not forwarded to master port %0d",
                             i, t));
        end else begin
          claimed[t]   = 1'b1;
          got_id.raw   = m_ar_id[t];
          exp_id.f.src = SRC_W'(i);
          exp_id.f.id  = s_ar_id[i];
          compare_req(t, got_id, exp_id, m_ar_addr[t], s_ar_addr[i]);
          push_expected(i, s_ar_id[i], s_ar_addr[i] ^ addr_t'(t), RESP_OKAY);
        end
      end
    end
    for (int j = 0; j < NUM_MST_PORTS; j++) begin
      if (m_ar_valid[j] && m_ar_ready[j] && !claimed[j]) begin
        stop_run($sformatf("master port %0d accepted a read no slave port sent to it", j));
      end
    end
  endtask

  task automatic check_responses();
    logic [ID_USED-1:0] tid;
    data_t              e_data;
    slv_id_t            e_id;
    resp_t              e_resp;
    for (int i = 0; i < NUM_SLV_PORTS; i++) begin
      if (s_r_valid[i] && s_r_ready[i]) begin
        tid = s_r_id[i][ID_USED-1:0];
        if (exp_data_q[i][tid].size() == 0) begin
          stop_run($sformatf("unexpected response with ID %h at slave port %0d",
                             s_r_id[i], i));
        end else begin
          e_data = exp_data_q[i][tid].pop_front();
          e_id   = exp_id_q[i][tid].pop_front();
          e_resp = exp_resp_q[i][tid].pop_front();
          compare_rsp(i, s_r_data[i], e_data, s_r_id[i], e_id, s_r_resp[i], e_resp);
        end
      end
    end
  endtask

  // In-order targets, random delay per response
  task automatic drive_targets();
    logic busy;
    for (int j = 0; j < NUM_MST_PORTS; j++) begin
      busy = m_r_valid[j];
      if (m_r_valid[j] && m_r_ready[j]) begin
        void'(tgt_addr_q[j].pop_front());
        void'(tgt_id_q[j].pop_front());
        busy         = 1'b0;
        m_r_valid[j] <= 1'b0;
      end
      if (m_ar_valid[j] && m_ar_ready[j]) begin
        tgt_addr_q[j].push_back(m_ar_addr[j]);
        tgt_id_q[j].push_back(m_ar_id[j]);
      end
      if (!busy && (tgt_addr_q[j].size() != 0)) begin
        if (tgt_dly[j] == 0) begin
          m_r_valid[j] <= 1'b1;
          m_r_data[j]  <= tgt_addr_q[j][0] ^ data_t'(j);
          m_r_id[j]    <= tgt_id_q[j][0];
          m_r_resp[j]  <= RESP_OKAY;
          tgt_dly[j]   = rand_next() % 6;
        end else begin
          tgt_dly[j] = tgt_dly[j] - 1;
        end
      end
      m_ar_ready[j] <= (rand_next() % 4) != 0;
    end
  endtask

  task automatic drive_initiators();
    addr_t       addr;
    logic        den;
    port_sel_t   dport;
    logic [31:0] r;
    for (int i = 0; i < NUM_SLV_PORTS; i++) begin
      if (s_ar_valid[i] && s_ar_ready[i]) begin
        s_ar_valid[i] <= 1'b0;
        issued[i]     = issued[i] + 1;
        gap[i]        = rand_next() % 4;
      end else if (!s_ar_valid[i] && (issued[i] < NUM_READS)) begin
        if (gap[i] != 0) begin
          gap[i] = gap[i] - 1;
        end else begin
          den   = default_en[i];
          dport = default_port[i];
          // Default moves only between requests
          if ((rand_next() % 4) == 0) begin
            r     = rand_next();
            den   = r[0];
            dport = port_sel_t'((r >> 8) % NUM_MST_PORTS);
          end
          addr            = random_addr();
          pend_tgt[i]     = predict_target(addr, den, dport);
          default_en[i]   <= den;
          default_port[i] <= dport;
          s_ar_valid[i]   <= 1'b1;
          s_ar_addr[i]    <= addr;
          s_ar_id[i]      <= slv_id_t'(rand_next());
        end
      end
      s_r_ready[i] <= (rand_next() % 4) != 0;
    end
  endtask

  // Check on the edge first, then drive the next cycle
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_SLV_PORTS; i++) begin
        issued[i]   = 0;
        gap[i]      = 0;
        pend_tgt[i] = '0;
      end
      for (int j = 0; j < NUM_MST_PORTS; j++) begin
        tgt_dly[j] = 0;
      end
    end else begin
      check_requests();
      check_responses();
      drive_targets();
      drive_initiators();
    end
  end

  initial begin
    int unsigned wait_cnt;
    rst_n_i = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;

    wait_cnt = 0;
    while (!all_issued()) begin
      @(negedge clk_i);
      wait_cnt++;
      if (wait_cnt > ISSUE_TIMEOUT) begin
        stop_run("timeout while waiting for all reads to be issued");
      end
    end

    // Every accepted read still owes one response
    wait_cnt = 0;
    while (!all_drained()) begin
      @(negedge clk_i);
      wait_cnt++;
      if (wait_cnt > DRAIN_TIMEOUT) begin
        stop_run("timeout while waiting for outstanding responses to drain");
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* xbar_addr_decode.sv */
/*
  Read address decoder for one slave port.
  Maps an address to a master port, the default port or the error target.
*/
`default_nettype none

module xbar_addr_decode import xbar_pkg::*; (
  input  addr_t     ar_addr_i,
  input  logic      default_en_i,
  input  port_sel_t default_port_i,
  output port_sel_t sel_o
);

  logic      hit;
  port_sel_t hit_port;

  // Walk all rules, a later match overrides an earlier one
  always_comb begin
    hit      = 1'b0;
    hit_port = '0;
    for (int r = 0; r < NUM_RULES; r++) begin
      if ((ar_addr_i >= RULE_START[r]) && (ar_addr_i < RULE_END[r])) begin
        hit      = 1'b1;
        hit_port = RULE_PORT[r];
      end
    end
  end

  // Fallback order: map hit, then default port, then decode error
  always_comb begin
    if (hit) begin
      sel_o = hit_port;
    end else if (default_en_i) begin
      sel_o = default_port_i;
    end else begin
      sel_o = port_sel_t'(NUM_MST_PORTS);
    end
  end

endmodule

`default_nettype wire

/* xbar_decerr_slv.sv */
/*
  Decode-error target behind one slave port.
  Takes one read at a time and answers it a cycle later with DECERR.
*/
`default_nettype none

module xbar_decerr_slv import xbar_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  xbar_rd_if.target slv
);

  logic    pend_q;
  slv_id_t id_q;
  logic    ar_fire;
  logic    r_fire;

  assign ar_fire = slv.ar_valid && slv.ar_ready;
  assign r_fire  = slv.r_valid && slv.r_ready;

  // No new request while the single response slot is taken
  assign slv.ar_ready = !pend_q;

  assign slv.r_valid = pend_q;
  assign slv.r_data  = DECERR_DATA;
  assign slv.r_resp  = RESP_DECERR;
  assign slv.r_id    = id_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
    end else if (ar_fire) begin
      pend_q <= 1'b1;
    end else if (r_fire) begin
      pend_q <= 1'b0;
    end
  end

  // Echoed ID
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      id_q <= slv.ar_id;
    end
  end

  // Requester keeps a waiting read and its ID until the slot takes it
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv.ar_valid && !slv.ar_ready) |=> (slv.ar_valid && $stable(slv.ar_id)))
    else $error("decode-error request withdrawn before it was accepted");

endmodule

`default_nettype wire

/* xbar_pkg.sv */
/*
  Shared constants and types for the read-only crossbar.
  Import it with a wildcard in the module header. The address map lives here.
*/
`default_nettype none

package xbar_pkg;

  // Port counts
  localparam int unsigned NUM_SLV_PORTS = 2;
  localparam int unsigned NUM_MST_PORTS = 3;
  localparam int unsigned NUM_RULES     = 4;

  // Bus widths
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned SLV_ID_W = 4;
  localparam int unsigned SRC_W    = $clog2(NUM_SLV_PORTS);
  localparam int unsigned MST_ID_W = SLV_ID_W + SRC_W;

  // ID ordering, one counter per low ID value
  localparam int unsigned ID_USED   = 2;
  localparam int unsigned TRACK_NUM = 2 ** ID_USED;
  localparam int unsigned MAX_TRANS = 4;
  localparam int unsigned CNT_W     = $clog2(MAX_TRANS + 1);

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [SLV_ID_W-1:0] slv_id_t;
  typedef logic [1:0]          resp_t;
  // NUM_MST_PORTS selects the decode-error target
  typedef logic [1:0]          port_sel_t;

  // Master-side ID, raw word or source index over the slave ID
  typedef union packed {
    logic [MST_ID_W-1:0] raw;
    struct packed {
      logic [SRC_W-1:0] src;
      slv_id_t          id;
    } f;
  } mst_id_u;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;
  localparam data_t DECERR_DATA = 32'hdead_beef;

  // Start inclusive, end exclusive, highest matching rule wins
  // Rule 3 overlays a window of port 0, 0x3000_0000 and up is a hole
  localparam addr_t     RULE_START [NUM_RULES] = '{32'h0000_0000, 32'h1000_0000,
                                                   32'h2000_0000, 32'h0800_0000};
  localparam addr_t     RULE_END   [NUM_RULES] = '{32'h1000_0000, 32'h2000_0000,
                                                   32'h3000_0000, 32'h0900_0000};
  localparam port_sel_t RULE_PORT  [NUM_RULES] = '{2'd0, 2'd1, 2'd2, 2'd0};

endpackage

`default_nettype wire

/* xbar_rd_demux.sv */
/*
  Slave port stage. Steers each read to the selected target and keeps
  per-ID ordering. Responses come back with fixed priority, lowest target first.
*/
`default_nettype none

module xbar_rd_demux import xbar_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  port_sel_t    sel_i,
  xbar_rd_if.target    slv,
  xbar_rd_if.initiator mst [NUM_MST_PORTS+1]
);

  localparam int unsigned NUM_TGT = NUM_MST_PORTS + 1;

  // Per-ID tracking
  logic [CNT_W-1:0] cnt_q [TRACK_NUM];
  logic [CNT_W-1:0] cnt_d [TRACK_NUM];
  port_sel_t        tgt_q [TRACK_NUM];

  logic [ID_USED-1:0] ar_idx;
  logic [ID_USED-1:0] r_idx;
  logic               stall;
  logic               ar_fire;
  logic               r_fire;

  // Gathered target signals
  logic [NUM_TGT-1:0] ar_ready_vec;
  logic [NUM_TGT-1:0] r_valid_vec;
  data_t              r_data_vec [NUM_TGT];
  slv_id_t            r_id_vec   [NUM_TGT];
  resp_t              r_resp_vec [NUM_TGT];

  // Response selection, held while the slave port stalls it
  port_sel_t r_pick;
  port_sel_t r_sel;
  port_sel_t r_lock_sel_q;
  logic      r_lock_q;

  assign ar_idx = slv.ar_id[ID_USED-1:0];
  assign r_idx  = slv.r_id[ID_USED-1:0];

  // Reads of this ID already head elsewhere, or too many outstanding
  assign stall = ((cnt_q[ar_idx] != '0) && (tgt_q[ar_idx] != sel_i)) ||
                 (cnt_q[ar_idx] == CNT_W'(MAX_TRANS));

  assign slv.ar_ready = !stall && ar_ready_vec[sel_i];
  assign ar_fire      = slv.ar_valid && slv.ar_ready;

  for (genvar j = 0; j < NUM_TGT; j++) begin : g_tgt
    // Request goes only to the selected target
    assign mst[j].ar_valid = slv.ar_valid && !stall && (sel_i == port_sel_t'(j));
    assign mst[j].ar_addr  = slv.ar_addr;
    assign mst[j].ar_id    = slv.ar_id;
    assign ar_ready_vec[j] = mst[j].ar_ready;

    assign r_valid_vec[j] = mst[j].r_valid;
    assign r_data_vec[j]  = mst[j].r_data;
    assign r_id_vec[j]    = mst[j].r_id;
    assign r_resp_vec[j]  = mst[j].r_resp;
    assign mst[j].r_ready = slv.r_ready && (r_sel == port_sel_t'(j));
  end

  // Lowest valid index wins
  always_comb begin
    r_pick = port_sel_t'(NUM_MST_PORTS);
    for (int j = NUM_TGT - 1; j >= 0; j--) begin
      if (r_valid_vec[j]) begin
        r_pick = port_sel_t'(j);
      end
    end
  end

  assign r_sel = r_lock_q ? r_lock_sel_q : r_pick;

  assign slv.r_valid = r_valid_vec[r_sel];
  assign slv.r_data  = r_data_vec[r_sel];
  assign slv.r_id    = r_id_vec[r_sel];
  assign slv.r_resp  = r_resp_vec[r_sel];
  assign r_fire      = slv.r_valid && slv.r_ready;

  // Count up on request, down on response
  always_comb begin
    for (int t = 0; t < TRACK_NUM; t++) begin
      cnt_d[t] = cnt_q[t];
    end
    if (ar_fire) begin
      cnt_d[ar_idx] = cnt_d[ar_idx] + 1'b1;
    end
    if (r_fire) begin
      cnt_d[r_idx] = cnt_d[r_idx] - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int t = 0; t < TRACK_NUM; t++) begin
        cnt_q[t] <= '0;
        tgt_q[t] <= '0;
      end
      r_lock_q     <= 1'b0;
      r_lock_sel_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      if (ar_fire) begin
        tgt_q[ar_idx] <= sel_i;
      end
      r_lock_q     <= slv.r_valid && !slv.r_ready;
      r_lock_sel_q <= r_sel;
    end
  end

  // Decoder inputs must not move under a waiting request
  a_sel_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv.ar_valid && !slv.ar_ready) |=> $stable(sel_i))
    else $error("demux select changed under a pending request");

  // Every response matches an earlier counted request
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_fire |-> (cnt_q[r_idx] != '0))
    else $error("demux response without outstanding read");

endmodule

`default_nettype wire

/* xbar_rd_if.sv */
/*
  One read request and read response channel pair.
  ID_W sets the ID width, slave side or master side.
*/
`default_nettype none

interface xbar_rd_if import xbar_pkg::*; #(
  parameter int unsigned ID_W = SLV_ID_W
);

  // Read request
  logic            ar_valid;
  logic            ar_ready;
  addr_t           ar_addr;
  logic [ID_W-1:0] ar_id;

  // Read response
  logic            r_valid;
  logic            r_ready;
  data_t           r_data;
  logic [ID_W-1:0] r_id;
  resp_t           r_resp;

  // Side that issues requests
  modport initiator (
    output ar_valid, ar_addr, ar_id, r_ready,
    input  ar_ready, r_valid, r_data, r_id, r_resp
  );

  // Side that answers them
  modport target (
    input  ar_valid, ar_addr, ar_id, r_ready,
    output ar_ready, r_valid, r_data, r_id, r_resp
  );

endinterface

`default_nettype wire

/* xbar_rd_mux.sv */
/*
  Master port stage. Round-robin over the slave ports.
  The source index goes above the ID on the way out and routes each response back.
*/
`default_nettype none

module xbar_rd_mux import xbar_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  xbar_rd_if.target    slv [NUM_SLV_PORTS],
  xbar_rd_if.initiator mst
);

  logic [NUM_SLV_PORTS-1:0] req_vec;
  logic [NUM_SLV_PORTS-1:0] r_ready_vec;
  addr_t                    addr_vec [NUM_SLV_PORTS];
  slv_id_t                  id_vec   [NUM_SLV_PORTS];

  // Arbitration state
  logic [SRC_W-1:0] rr_q;
  logic [SRC_W-1:0] gnt_free;
  logic [SRC_W-1:0] gnt;
  logic [SRC_W-1:0] lock_gnt_q;
  logic             lock_q;
  logic             ar_fire;

  mst_id_u req_id;
  mst_id_u rsp_id;

  assign rsp_id.raw = mst.r_id;

  for (genvar i = 0; i < NUM_SLV_PORTS; i++) begin : g_slv
    assign req_vec[i]  = slv[i].ar_valid;
    assign addr_vec[i] = slv[i].ar_addr;
    assign id_vec[i]   = slv[i].ar_id;
    assign slv[i].ar_ready = mst.ar_ready && (gnt == SRC_W'(i));

    // Response goes to the port named in the source field
    assign slv[i].r_valid = mst.r_valid && (rsp_id.f.src == SRC_W'(i));
    assign slv[i].r_data  = mst.r_data;
    assign slv[i].r_id    = rsp_id.f.id;
    assign slv[i].r_resp  = mst.r_resp;
    assign r_ready_vec[i] = slv[i].r_ready;
  end

  // First requester after the last winner
  always_comb begin
    int unsigned cand;
    gnt_free = rr_q;
    for (int k = NUM_SLV_PORTS; k >= 1; k--) begin
      cand = (int'(rr_q) + k) % NUM_SLV_PORTS;
      if (req_vec[cand]) begin
        gnt_free = SRC_W'(cand);
      end
    end
  end

  // A raised request keeps its grant until it transfers
  assign gnt = lock_q ? lock_gnt_q : gnt_free;

  always_comb begin
    req_id.f.src = gnt;
    req_id.f.id  = id_vec[gnt];
  end

  assign mst.ar_valid = req_vec[gnt];
  assign mst.ar_addr  = addr_vec[gnt];
  assign mst.ar_id    = req_id.raw;
  assign mst.r_ready  = r_ready_vec[rsp_id.f.src];
  assign ar_fire      = mst.ar_valid && mst.ar_ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q       <= SRC_W'(NUM_SLV_PORTS - 1);
      lock_q     <= 1'b0;
      lock_gnt_q <= '0;
    end else begin
      lock_q     <= mst.ar_valid && !mst.ar_ready;
      lock_gnt_q <= gnt;
      if (ar_fire) begin
        rr_q <= gnt;
      end
    end
  end

  // Waiting request and its payload hold until the target takes it
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst.ar_valid && !mst.ar_ready) |=>
      (mst.ar_valid && $stable(mst.ar_id) && $stable(mst.ar_addr)))
    else $error("mux request changed before it was accepted");

endmodule

`default_nettype wire

/* xbar_rd_top.sv */
/*
  Read-only crossbar top with flat ports on both sides.
  Per slave port a decoder, demux and error target; per master port a mux.
*/
`default_nettype none

module xbar_rd_top import xbar_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  // Slave ports, initiators connect here
  input  logic      [NUM_SLV_PORTS-1:0] s_ar_valid_i,
  input  addr_t     [NUM_SLV_PORTS-1:0] s_ar_addr_i,
  input  slv_id_t   [NUM_SLV_PORTS-1:0] s_ar_id_i,
  input  logic      [NUM_SLV_PORTS-1:0] s_r_ready_i,
  input  logic      [NUM_SLV_PORTS-1:0] default_en_i,
  input  port_sel_t [NUM_SLV_PORTS-1:0] default_port_i,
  output logic      [NUM_SLV_PORTS-1:0] s_ar_ready_o,
  output logic      [NUM_SLV_PORTS-1:0] s_r_valid_o,
  output data_t     [NUM_SLV_PORTS-1:0] s_r_data_o,
  output slv_id_t   [NUM_SLV_PORTS-1:0] s_r_id_o,
  output resp_t     [NUM_SLV_PORTS-1:0] s_r_resp_o,
  // Master ports, targets connect here
  output logic  [NUM_MST_PORTS-1:0]               m_ar_valid_o,
  output addr_t [NUM_MST_PORTS-1:0]               m_ar_addr_o,
  output logic  [NUM_MST_PORTS-1:0][MST_ID_W-1:0] m_ar_id_o,
  output logic  [NUM_MST_PORTS-1:0]               m_r_ready_o,
  input  logic  [NUM_MST_PORTS-1:0]               m_ar_ready_i,
  input  logic  [NUM_MST_PORTS-1:0]               m_r_valid_i,
  input  data_t [NUM_MST_PORTS-1:0]               m_r_data_i,
  input  logic  [NUM_MST_PORTS-1:0][MST_ID_W-1:0] m_r_id_i,
  input  resp_t [NUM_MST_PORTS-1:0]               m_r_resp_i
);

  // Crossing point, indexed [slave port][master port]
  logic    [NUM_SLV_PORTS-1:0][NUM_MST_PORTS-1:0] x_ar_valid;
  logic    [NUM_SLV_PORTS-1:0][NUM_MST_PORTS-1:0] x_ar_ready;
  addr_t   [NUM_SLV_PORTS-1:0][NUM_MST_PORTS-1:0] x_ar_addr;
  slv_id_t [NUM_SLV_PORTS-1:0][NUM_MST_PORTS-1:0] x_ar_id;
  logic    [NUM_SLV_PORTS-1:0][NUM_MST_PORTS-1:0] x_r_valid;
  logic    [NUM_SLV_PORTS-1:0][NUM_MST_PORTS-1:0] x_r_ready;
  data_t   [NUM_SLV_PORTS-1:0][NUM_MST_PORTS-1:0] x_r_data;
  slv_id_t [NUM_SLV_PORTS-1:0][NUM_MST_PORTS-1:0] x_r_id;
  resp_t   [NUM_SLV_PORTS-1:0][NUM_MST_PORTS-1:0] x_r_resp;

  for (genvar i = 0; i < NUM_SLV_PORTS; i++) begin : g_slv
    port_sel_t sel;

    xbar_rd_if #(.ID_W(SLV_ID_W)) port_bus ();
    // Last element feeds the error target
    xbar_rd_if #(.ID_W(SLV_ID_W)) dmx_bus [NUM_MST_PORTS+1] ();

    assign port_bus.ar_valid = s_ar_valid_i[i];
    assign port_bus.ar_addr  = s_ar_addr_i[i];
    assign port_bus.ar_id    = s_ar_id_i[i];
    assign port_bus.r_ready  = s_r_ready_i[i];
    assign s_ar_ready_o[i]   = port_bus.ar_ready;
    assign s_r_valid_o[i]    = port_bus.r_valid;
    assign s_r_data_o[i]     = port_bus.r_data;
    assign s_r_id_o[i]       = port_bus.r_id;
    assign s_r_resp_o[i]     = port_bus.r_resp;

    xbar_addr_decode u_dec (
      .ar_addr_i      (s_ar_addr_i[i]),
      .default_en_i   (default_en_i[i]),
      .default_port_i (default_port_i[i]),
      .sel_o          (sel)
    );

    xbar_rd_demux u_dmx (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .sel_i   (sel),
      .slv     (port_bus),
      .mst     (dmx_bus)
    );

    xbar_decerr_slv u_err (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .slv     (dmx_bus[NUM_MST_PORTS])
    );

    for (genvar j = 0; j < NUM_MST_PORTS; j++) begin : g_x
      assign x_ar_valid[i][j]     = dmx_bus[j].ar_valid;
      assign x_ar_addr[i][j]      = dmx_bus[j].ar_addr;
      assign x_ar_id[i][j]        = dmx_bus[j].ar_id;
      assign x_r_ready[i][j]      = dmx_bus[j].r_ready;
      assign dmx_bus[j].ar_ready  = x_ar_ready[i][j];
      assign dmx_bus[j].r_valid   = x_r_valid[i][j];
      assign dmx_bus[j].r_data    = x_r_data[i][j];
      assign dmx_bus[j].r_id      = x_r_id[i][j];
      assign dmx_bus[j].r_resp    = x_r_resp[i][j];
    end
  end

  for (genvar j = 0; j < NUM_MST_PORTS; j++) begin : g_mst
    xbar_rd_if #(.ID_W(SLV_ID_W)) mux_bus [NUM_SLV_PORTS] ();
    xbar_rd_if #(.ID_W(MST_ID_W)) port_bus ();

    // Transposed view of the crossing point
    for (genvar i = 0; i < NUM_SLV_PORTS; i++) begin : g_x
      assign mux_bus[i].ar_valid = x_ar_valid[i][j];
      assign mux_bus[i].ar_addr  = x_ar_addr[i][j];
      assign mux_bus[i].ar_id    = x_ar_id[i][j];
      assign mux_bus[i].r_ready  = x_r_ready[i][j];
      assign x_ar_ready[i][j]    = mux_bus[i].ar_ready;
      assign x_r_valid[i][j]     = mux_bus[i].r_valid;
      assign x_r_data[i][j]      = mux_bus[i].r_data;
      assign x_r_id[i][j]        = mux_bus[i].r_id;
      assign x_r_resp[i][j]      = mux_bus[i].r_resp;
    end

    xbar_rd_mux u_mux (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .slv     (mux_bus),
      .mst     (port_bus)
    );

    assign m_ar_valid_o[j]   = port_bus.ar_valid;
    assign m_ar_addr_o[j]    = port_bus.ar_addr;
    assign m_ar_id_o[j]      = port_bus.ar_id;
    assign m_r_ready_o[j]    = port_bus.r_ready;
    assign port_bus.ar_ready = m_ar_ready_i[j];
    assign port_bus.r_valid  = m_r_valid_i[j];
    assign port_bus.r_data   = m_r_data_i[j];
    assign port_bus.r_id     = m_r_id_i[j];
    assign port_bus.r_resp   = m_r_resp_i[j];
  end

endmodule

`default_nettype wire
